// ==== rtl/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// datapath and address width
`define LSU_XLEN 32

// timer word addresses
// mtime lives in the upper block, mtimecmp in the lower one
`define LSU_MTIME_LO    32'h0200_BFF8
`define LSU_MTIME_HI    32'h0200_BFFC
`define LSU_MTIMECMP_LO 32'h0200_4000
`define LSU_MTIMECMP_HI 32'h0200_4004

// sc.w result written back to rd
// zero means the store happened
`define LSU_SC_OK   32'd0
`define LSU_SC_FAIL 32'd1

// cache model answer delay in cycles
// counted from the rise of request valid
`define LSU_DC_DELAY 2

`endif

// ==== rtl/lsu_pkg.sv ====
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

    // memory operation handed over by the execute stage
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LBU  = 4'd2,
        LH   = 4'd3,
        LHU  = 4'd4,
        LW   = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8,
        LR_W = 4'd9,
        SC_W = 4'd10,
        AMO  = 4'd11
    } mem_op_e;

    // read-modify-write flavour, only looked at for AMO
    typedef enum logic [3:0] {
        SWAP = 4'd0,
        ADD  = 4'd1,
        XOR  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        MIN  = 4'd5,
        MAX  = 4'd6,
        MINU = 4'd7,
        MAXU = 4'd8
    } amo_op_e;

    // decoded control, size is one-hot byte/half/word
    typedef struct packed {
        logic       is_load;
        logic       is_store;
        logic       is_atomic;
        logic       is_signed;
        logic [3:0] size;
    } lsu_ctrl_t;

    // data cache request
    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [`LSU_XLEN-1:0] addr;
        logic [3:0]           mask;
        logic [`LSU_XLEN-1:0] wdata;
        logic [3:0]           size;
    } dcache_req_t;

    // timer request, no handshake
    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] wdata;
    } clint_req_t;

    // atomic unit access to the cache, always a full word
    typedef struct packed {
        logic                 rd;
        logic                 wr;
        logic [`LSU_XLEN-1:0] wdata;
    } amo_mem_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_op_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_op_decode import lsu_pkg::*; (
    input  mem_op_e   mem_op_i,
    output lsu_ctrl_t ctrl_o
);

    always_comb begin
        // nothing active for NONE or unknown codes
        ctrl_o = '0;
        case (mem_op_i)
            LB, LBU: begin
                ctrl_o.is_load   = 1'b1;
                ctrl_o.is_signed = (mem_op_i == LB);
                ctrl_o.size      = 4'b0001;
            end
            LH, LHU: begin
                ctrl_o.is_load   = 1'b1;
                ctrl_o.is_signed = (mem_op_i == LH);
                ctrl_o.size      = 4'b0010;
            end
            LW: begin
                // full word, sign flag has no effect
                ctrl_o.is_load   = 1'b1;
                ctrl_o.is_signed = 1'b1;
                ctrl_o.size      = 4'b0100;
            end
            SB: begin
                ctrl_o.is_store = 1'b1;
                ctrl_o.size     = 4'b0001;
            end
            SH: begin
                ctrl_o.is_store = 1'b1;
                ctrl_o.size     = 4'b0010;
            end
            SW: begin
                ctrl_o.is_store = 1'b1;
                ctrl_o.size     = 4'b0100;
            end
            LR_W, SC_W, AMO: begin
                // atomics are word only
                ctrl_o.is_atomic = 1'b1;
                ctrl_o.size      = 4'b0100;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_lane_align.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_lane_align import lsu_pkg::*; (
    input  lsu_ctrl_t            ctrl_i,
    input  logic [1:0]           addr_lo_i,
    input  logic [`LSU_XLEN-1:0] store_data_i,
    input  logic [`LSU_XLEN-1:0] load_data_i,
    output logic [3:0]           rmask_o,
    output logic [3:0]           wmask_o,
    output logic [`LSU_XLEN-1:0] wdata_o,
    output logic [`LSU_XLEN-1:0] load_ext_o
);

    logic byte_sign;
    logic half_sign;

    // size mask, right-justified
    assign rmask_o = ({4{ctrl_i.size[0]}} & 4'b0001) |
                     ({4{ctrl_i.size[1]}} & 4'b0011) |
                     ({4{ctrl_i.size[2]}} & 4'b1111);

    // write lanes follow the low address bits
    assign wmask_o = rmask_o << addr_lo_i;
    // one byte lane per address step
    assign wdata_o = store_data_i << {addr_lo_i, 3'b000};

    // sign bits only matter for lb and lh
    assign byte_sign = ctrl_i.is_signed & load_data_i[7];
    assign half_sign = ctrl_i.is_signed & load_data_i[15];

    // cache returns the addressed lanes at bit 0
    always_comb begin
        if (ctrl_i.size[0]) begin
            load_ext_o = {{(`LSU_XLEN-8){byte_sign}}, load_data_i[7:0]};
        end else if (ctrl_i.size[1]) begin
            load_ext_o = {{(`LSU_XLEN-16){half_sign}}, load_data_i[15:0]};
        end else begin
            // word or no size, nothing to extend
            load_ext_o = load_data_i;
        end
    end

    // decode hands over at most one size bit
    always_comb begin
        assert ($onehot0(ctrl_i.size))
            else $error("lsu_lane_align: size is not one-hot");
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_amo_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_amo_unit import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  lsu_ctrl_t            ctrl_i,
    input  mem_op_e              mem_op_i,
    input  amo_op_e              amo_op_i,
    input  logic [`LSU_XLEN-1:0] addr_i,
    input  logic [`LSU_XLEN-1:0] rs2_i,
    input  logic                 plain_store_i,
    input  logic                 ready_i,
    input  logic [`LSU_XLEN-1:0] rdata_i,
    output amo_mem_t             mem_o,
    output logic [`LSU_XLEN-1:0] result_o,
    output logic                 done_o,
    output logic                 busy_o,
    output logic                 misalign_o
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        CALC,
        STORE
    } amo_state_e;

    amo_state_e           state;
    logic [`LSU_XLEN-1:0] loaded_q;
    logic [`LSU_XLEN-1:0] new_val_q;
    logic [`LSU_XLEN-1:0] calc_val;
    logic [`LSU_XLEN-1:0] resv_addr_q;
    logic                 resv_valid_q;
    logic                 start;
    logic                 sc_match;
    logic                 load_done;

    assign misalign_o = ctrl_i.is_atomic & (addr_i[1:0] != 2'b00);
    // held op must not restart while done is still showing
    assign start     = ctrl_i.is_atomic & ~misalign_o & (state == IDLE) & ~done_o;
    assign sc_match  = resv_valid_q & (resv_addr_q == addr_i);
    assign load_done = (state == LOAD) & ready_i;
    assign busy_o    = (state != IDLE) | start;

    // cache side gets one direction per state
    assign mem_o.rd    = (state == LOAD);
    assign mem_o.wr    = (state == STORE);
    assign mem_o.wdata = (mem_op_i == SC_W) ? rs2_i : new_val_q;

    // read-modify-write arithmetic on the loaded word
    always_comb begin
        case (amo_op_i)
            SWAP:    calc_val = rs2_i;
            ADD:     calc_val = loaded_q + rs2_i;
            XOR:     calc_val = loaded_q ^ rs2_i;
            AND:     calc_val = loaded_q & rs2_i;
            OR:      calc_val = loaded_q | rs2_i;
            MIN:     calc_val = ($signed(loaded_q) < $signed(rs2_i)) ? loaded_q : rs2_i;
            MAX:     calc_val = ($signed(loaded_q) > $signed(rs2_i)) ? loaded_q : rs2_i;
            MINU:    calc_val = (loaded_q < rs2_i) ? loaded_q : rs2_i;
            MAXU:    calc_val = (loaded_q > rs2_i) ? loaded_q : rs2_i;
            default: calc_val = rs2_i;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            done_o       <= 1'b0;
            resv_valid_q <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (start && mem_op_i == SC_W) begin
                        if (sc_match) begin
                            state <= STORE;
                        end else begin
                            // failed sc finishes at once without a write
                            done_o       <= 1'b1;
                            resv_valid_q <= 1'b0;
                        end
                    end else if (start) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (ready_i && mem_op_i == LR_W) begin
                        done_o       <= 1'b1;
                        resv_valid_q <= 1'b1;
                        state        <= IDLE;
                    end else if (ready_i) begin
                        state <= CALC;
                    end
                end
                CALC: state <= STORE;
                STORE: begin
                    // sc and amo both drop the reservation
                    if (ready_i) begin
                        done_o       <= 1'b1;
                        resv_valid_q <= 1'b0;
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (plain_store_i) begin
                resv_valid_q <= 1'b0;
            end
        end
    end

    // payload captured on the relevant step only
    always_ff @(posedge clk) begin
        if (load_done) begin
            loaded_q <= rdata_i;
            // old value is the result of lr and amo alike
            result_o <= rdata_i;
        end
        if (load_done && mem_op_i == LR_W) begin
            resv_addr_q <= addr_i;
        end
        if (state == CALC) begin
            new_val_q <= calc_val;
        end
        if (start && mem_op_i == SC_W && !sc_match) begin
            result_o <= `LSU_SC_FAIL;
        end else if (state == STORE && ready_i && mem_op_i == SC_W) begin
            result_o <= `LSU_SC_OK;
        end
    end

    // lr never writes and sc never reads while its op is held
    a_dir_op: assert property (@(posedge clk) disable iff (rst)
        !(mem_o.rd && mem_op_i == SC_W) && !(mem_o.wr && mem_op_i == LR_W));

    // done never lasts two cycles, else the held op would be seen twice
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done_o |=> !done_o);

    a_misalign_idle: assert property (@(posedge clk) disable iff (rst)
        misalign_o |-> (state == IDLE));

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_top import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_op_e              mem_op_i,
    input  amo_op_e              amo_op_i,
    input  logic [`LSU_XLEN-1:0] alu_data_i,
    input  logic [`LSU_XLEN-1:0] rs2_data_i,
    input  logic                 dcache_ready_i,
    input  logic [`LSU_XLEN-1:0] dcache_rdata_i,
    input  logic [`LSU_XLEN-1:0] clint_rdata_i,
    output dcache_req_t          dcache_req_o,
    output clint_req_t           clint_req_o,
    output logic [`LSU_XLEN-1:0] mem_data_o,
    output logic [`LSU_XLEN-1:0] amo_result_o,
    output logic                 amo_done_o,
    output logic                 amo_misalign_o,
    output logic                 stall_o
);

    lsu_ctrl_t            ctrl;
    amo_mem_t             amo_mem;
    logic [3:0]           rmask;
    logic [3:0]           wmask;
    logic [`LSU_XLEN-1:0] wdata_aligned;
    logic [`LSU_XLEN-1:0] load_raw;
    logic [`LSU_XLEN-1:0] load_ext;
    logic                 clint_hit;
    logic                 plain_access;
    logic                 plain_req;
    logic                 plain_valid;
    logic                 amo_req;
    logic                 amo_busy;
    logic                 plain_store_done;

    lsu_op_decode op_decode_inst (
        .mem_op_i (mem_op_i),
        .ctrl_o   (ctrl)
    );

    // address is the alu result, no translation
    assign clint_hit = (alu_data_i == `LSU_MTIME_LO)    |
                       (alu_data_i == `LSU_MTIME_HI)    |
                       (alu_data_i == `LSU_MTIMECMP_LO) |
                       (alu_data_i == `LSU_MTIMECMP_HI);

    assign plain_access = ctrl.is_load | ctrl.is_store;
    assign plain_req    = plain_access & ~clint_hit;
    // valid drops in the ready cycle
    assign plain_valid  = plain_req & ~dcache_ready_i;
    assign amo_req      = amo_mem.rd | amo_mem.wr;

    // timer stores finish in zero cycles, cache stores on ready
    assign plain_store_done = ctrl.is_store & (clint_hit | dcache_ready_i);

    // read data is only meaningful in the completion cycle
    assign load_raw = clint_hit      ? clint_rdata_i  :
                      dcache_ready_i ? dcache_rdata_i : '0;

    lsu_lane_align lane_align_inst (
        .ctrl_i       (ctrl),
        .addr_lo_i    (alu_data_i[1:0]),
        .store_data_i (rs2_data_i),
        .load_data_i  (load_raw),
        .rmask_o      (rmask),
        .wmask_o      (wmask),
        .wdata_o      (wdata_aligned),
        .load_ext_o   (load_ext)
    );

    lsu_amo_unit amo_unit_inst (
        .clk           (clk),
        .rst           (rst),
        .ctrl_i        (ctrl),
        .mem_op_i      (mem_op_i),
        .amo_op_i      (amo_op_i),
        .addr_i        (alu_data_i),
        .rs2_i         (rs2_data_i),
        .plain_store_i (plain_store_done),
        .ready_i       (dcache_ready_i),
        .rdata_i       (dcache_rdata_i),
        .mem_o         (amo_mem),
        .result_o      (amo_result_o),
        .done_o        (amo_done_o),
        .busy_o        (amo_busy),
        .misalign_o    (amo_misalign_o)
    );

    // merge plain and atomic cache traffic
    always_comb begin
        dcache_req_o.valid = (plain_req | amo_req) & ~dcache_ready_i;
        dcache_req_o.write = amo_req ? amo_mem.wr : ctrl.is_store;
        dcache_req_o.addr  = alu_data_i;
        // atomics are aligned words, no lane shift
        dcache_req_o.mask  = amo_req ? 4'b1111 : (ctrl.is_store ? wmask : rmask);
        dcache_req_o.wdata = amo_req ? amo_mem.wdata : wdata_aligned;
        dcache_req_o.size  = ctrl.size;
    end

    // timer port, atomics never go here
    assign clint_req_o.valid = plain_access & clint_hit;
    assign clint_req_o.write = ctrl.is_store;
    assign clint_req_o.addr  = alu_data_i;
    assign clint_req_o.wdata = rs2_data_i;

    always_comb begin
        if (ctrl.is_atomic) begin
            mem_data_o = amo_result_o;
        end else if (ctrl.is_load) begin
            mem_data_o = load_ext;
        end else begin
            // non-memory ops pass the alu result
            mem_data_o = alu_data_i;
        end
    end

    assign stall_o = plain_valid | amo_busy;

    // a request goes to exactly one port
    a_port_excl: assert property (@(posedge clk) disable iff (rst)
        !(dcache_req_o.valid && clint_req_o.valid));

endmodule

`default_nettype wire

// ==== tb/dcache_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module dcache_model import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_req_t          req_i,
    output logic                 ready_o,
    output logic [`LSU_XLEN-1:0] rdata_o
);

    logic [`LSU_XLEN-1:0] mem [0:63];
    logic [5:0]           idx;
    int unsigned          wait_cnt;

    // 64 words, upper address bits alias
    assign idx = req_i.addr[7:2];

    // addressed lanes moved down to bit 0
    assign rdata_o = ready_o ? (mem[idx] >> {req_i.addr[1:0], 3'b000}) : '0;

    initial begin
        // every word differs, sign bits mixed
        for (int i = 0; i < 64; i++) begin
            mem[i] = (i * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
        end
    end

    // ready pulses LSU_DC_DELAY cycles after valid rises
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_o  <= 1'b0;
            wait_cnt <= 0;
        end else if (ready_o || !req_i.valid) begin
            // pulse over or nothing pending
            ready_o  <= 1'b0;
            wait_cnt <= 0;
        end else if (wait_cnt == `LSU_DC_DELAY - 1) begin
            ready_o  <= 1'b1;
            wait_cnt <= 0;
        end else begin
            wait_cnt <= wait_cnt + 1;
        end
    end

    // write lands at the end of the ready cycle, masked lanes only
    always @(posedge clk) begin
        if (ready_o && req_i.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.mask[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_lsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_settings.svh"

module tb_lsu_top import lsu_pkg::*; ();

    localparam int PERIOD  = 40;
    // longest atomic plus the gap before the next op
    localparam int WORST   = 2 * `LSU_DC_DELAY + 6;
    localparam int MAX_OPS = 120;

    logic        clk;
    logic        rst;
    mem_op_e     mem_op;
    amo_op_e     amo_op;
    logic [31:0] alu_data;
    logic [31:0] rs2_data;
    logic [31:0] clint_rdata;
    logic [31:0] dc_rdata;
    logic [31:0] mem_data;
    logic [31:0] amo_result;
    logic        dc_ready;
    logic        amo_done;
    logic        amo_misalign;
    logic        stall;
    dcache_req_t dc_req;
    clint_req_t  clint_req;

    // what the ports showed in the first cycle of the last op
    dcache_req_t req_seen;
    clint_req_t  clint_seen;
    logic        misalign_seen;

    logic [31:0] ref_mem [0:63];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          ops;
    int          tests;
    int          last_err;
    int          last_chk;
    logic [31:0] timer_addr [4] = '{`LSU_MTIME_LO, `LSU_MTIME_HI,
                                    `LSU_MTIMECMP_LO, `LSU_MTIMECMP_HI};
    mem_op_e     load_ops [5] = '{LB, LBU, LH, LHU, LW};

    always #(PERIOD / 2) clk = ~clk;

    lsu_top lsu_top_inst (
        .clk            (clk),
        .rst            (rst),
        .mem_op_i       (mem_op),
        .amo_op_i       (amo_op),
        .alu_data_i     (alu_data),
        .rs2_data_i     (rs2_data),
        .dcache_ready_i (dc_ready),
        .dcache_rdata_i (dc_rdata),
        .clint_rdata_i  (clint_rdata),
        .dcache_req_o   (dc_req),
        .clint_req_o    (clint_req),
        .mem_data_o     (mem_data),
        .amo_result_o   (amo_result),
        .amo_done_o     (amo_done),
        .amo_misalign_o (amo_misalign),
        .stall_o        (stall)
    );

    dcache_model cache_inst (
        .clk     (clk),
        .rst     (rst),
        .req_i   (dc_req),
        .ready_o (dc_ready),
        .rdata_o (dc_rdata)
    );

    // plain cache traffic stalls exactly while its request waits
    a_plain_stall: assert property (@(posedge clk) disable iff (rst)
        (mem_op inside {LB, LBU, LH, LHU, LW, SB, SH, SW}) |-> (stall == dc_req.valid))
    else begin
        errors++;
        $display("ERROR %0t stall_o %b expected %b", $time, $sampled(stall),
                 $sampled(dc_req.valid));
    end

    // timer and misaligned atomics leave cache port and pipeline alone
    a_quiet: assert property (@(posedge clk) disable iff (rst)
        (clint_req.valid || amo_misalign) |-> (!dc_req.valid && !stall))
    else begin
        errors++;
        $display("ERROR %0t dcache_req_o.valid/stall_o %b%b expected 00", $time,
                 $sampled(dc_req.valid), $sampled(stall));
    end

    a_done_free: assert property (@(posedge clk) disable iff (rst) amo_done |-> !stall)
    else begin
        errors++;
        $display("ERROR %0t stall_o %b expected 0 in done cycle", $time, $sampled(stall));
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic is_timer(input logic [31:0] addr);
        return addr inside {`LSU_MTIME_LO, `LSU_MTIME_HI,
                            `LSU_MTIMECMP_LO, `LSU_MTIMECMP_HI};
    endfunction

    function automatic int op_bytes(input mem_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    function automatic logic [3:0] size_mask(input mem_op_e op);
        return (op_bytes(op) == 1) ? 4'b0001 : (op_bytes(op) == 2) ? 4'b0011 : 4'b1111;
    endfunction

    // byte lanes follow the address and upper lanes drop out
    function automatic void ref_store(input mem_op_e op, input logic [31:0] addr,
                                      input logic [31:0] data);
        logic [3:0]  m;
        logic [31:0] d;
        m = size_mask(op) << addr[1:0];
        d = data << (8 * addr[1:0]);
        for (int b = 0; b < 4; b++) begin
            if (m[b]) ref_mem[addr[7:2]][8*b +: 8] = d[8*b +: 8];
        end
    endfunction

    function automatic logic [31:0] load_expect(input mem_op_e op, input logic [31:0] addr);
        logic [31:0] w;
        w = ref_mem[addr[7:2]] >> (8 * addr[1:0]);
        case (op)
            LB:      return {{24{w[7]}}, w[7:0]};
            LBU:     return {24'h0, w[7:0]};
            LH:      return {{16{w[15]}}, w[15:0]};
            LHU:     return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] amo_expect(input amo_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        case (op)
            ADD:     return a + b;
            XOR:     return a ^ b;
            AND:     return a & b;
            OR:      return a | b;
            MIN:     return ($signed(a) < $signed(b)) ? a : b;
            MAX:     return ($signed(a) > $signed(b)) ? a : b;
            MINU:    return (a < b) ? a : b;
            MAXU:    return (a > b) ? a : b;
            default: return b;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // present one op on the falling edge and wait for its completion cycle
    task automatic run_op(input mem_op_e op, input amo_op_e aop, input logic [31:0] addr,
                          input logic [31:0] rs2, output logic [31:0] data);
        int   waited;
        logic exp_stall;
        if (op inside {LR_W, SC_W, AMO}) begin
            exp_stall = (addr[1:0] == 2'b00);
        end else begin
            exp_stall = (op != NONE) && !is_timer(addr);
        end
        @(negedge clk);
        mem_op   = op;
        amo_op   = aop;
        alu_data = addr;
        rs2_data = rs2;
        ops++;
        #1;
        req_seen      = dc_req;
        clint_seen    = clint_req;
        misalign_seen = amo_misalign;
        check("stall_o", stall, exp_stall);
        waited = 0;
        while (stall && waited < 4 * WORST) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (stall) begin
            errors++;
            $display("%s at %h never completed, stall still high after %0d cycles",
                     op.name(), addr, waited);
        end else if (exp_stall) begin
            // stall may only fall with ready or done
            check("dcache_ready_i|amo_done_o", dc_ready | amo_done, 1'b1);
        end
        data = (op inside {LR_W, SC_W, AMO}) ? amo_result : mem_data;
    endtask

    task automatic load_check(input mem_op_e op, input logic [31:0] addr);
        logic [31:0] got;
        run_op(op, SWAP, addr, 32'h0, got);
        check("mem_data_o", got, load_expect(op, addr));
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-8s done: %0d checks, %0d errors", name, checks - last_chk,
                 errors - last_err);
        last_chk = checks;
        last_err = errors;
    endtask

    // watchdog sized from the op budget
    initial begin
        #(PERIOD * (MAX_OPS * WORST + 10));
        $display("watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] old;
        logic [31:0] got;
        logic [3:0]  exp_mask;
        clk         = 1'b0;
        rst         = 1'b1;
        mem_op      = NONE;
        amo_op      = SWAP;
        alu_data    = '0;
        rs2_data    = '0;
        clint_rdata = '0;
        lfsr        = 32'hc095_906d;
        errors      = 0;
        checks      = 0;
        ops         = 0;
        tests       = 0;
        last_err    = 0;
        last_chk    = 0;
        repeat (5) @(posedge clk);
        #1;
        check("stall_o", stall, 1'b0);
        check("amo_done_o", amo_done, 1'b0);
        check("amo_misalign_o", amo_misalign, 1'b0);
        check("dcache_req_o.valid", dc_req.valid, 1'b0);
        check("clint_req_o.valid", clint_req.valid, 1'b0);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 64; i++) ref_mem[i] = cache_inst.mem[i];
        end_test("reset");

        // stores at every lane and then all load kinds
        for (int sz = 0; sz < 3; sz++) begin
            for (int lane = 0; lane < 4; lane++) begin
                op       = (sz == 0) ? SB : (sz == 1) ? SH : SW;
                addr     = 32'h1000_0000 | (rand_bits(6) << 2) | lane;
                data     = rand_bits(32);
                exp_mask = size_mask(op) << lane;
                run_op(op, SWAP, addr, data, got);
                check("dcache_req_o.write", req_seen.write, 1'b1);
                check("dcache_req_o.addr", req_seen.addr, addr);
                check("dcache_req_o.size", req_seen.size, 4'b0001 << sz);
                check("dcache_req_o.mask", req_seen.mask, exp_mask);
                check("dcache_req_o.wdata", req_seen.wdata, data << (8 * lane));
                ref_store(op, addr, data);
            end
        end
        for (int k = 0; k < 20; k++) begin
            op   = load_ops[k % 5];
            addr = 32'h1000_0000 | (rand_bits(8) & ~(op_bytes(op) - 1));
            load_check(op, addr);
            check("dcache_req_o.mask", req_seen.mask, size_mask(op));
            check("dcache_req_o.write", req_seen.write, 1'b0);
        end
        end_test("plain");

        for (int t = 0; t < 4; t++) begin
            data = rand_bits(32);
            run_op(SW, SWAP, timer_addr[t], data, got);
            check("clint_req_o.valid", clint_seen.valid, 1'b1);
            check("clint_req_o.write", clint_seen.write, 1'b1);
            check("clint_req_o.addr", clint_seen.addr, timer_addr[t]);
            check("clint_req_o.wdata", clint_seen.wdata, data);
            check("dcache_req_o.valid", req_seen.valid, 1'b0);
            @(negedge clk);
            clint_rdata = rand_bits(32);
            run_op(LW, SWAP, timer_addr[t], 32'h0, got);
            check("clint_req_o.write", clint_seen.write, 1'b0);
            check("mem_data_o", got, clint_rdata);
        end
        end_test("timer");

        // second round forces negative operands
        for (int r = 0; r < 2; r++) begin
            for (int a = 0; a < 9; a++) begin
                addr = 32'h1000_0000 | (rand_bits(6) << 2);
                data = rand_bits(32);
                if (r == 1) data[31] = 1'b1;
                old = ref_mem[addr[7:2]];
                run_op(AMO, amo_op_e'(a), addr, data, got);
                check("amo_result_o", got, old);
                ref_mem[addr[7:2]] = amo_expect(amo_op_e'(a), old, data);
                load_check(LW, addr);
            end
        end
        end_test("amo");

        addr = 32'h1000_0000 | (rand_bits(6) << 2);
        run_op(LR_W, SWAP, addr, 32'h0, got);
        check("amo_result_o", got, ref_mem[addr[7:2]]);
        data = rand_bits(32);
        run_op(SC_W, SWAP, addr, data, got);
        check("amo_result_o", got, `LSU_SC_OK);
        ref_mem[addr[7:2]] = data;
        load_check(LW, addr);
        // reservation used up by the first sc
        run_op(SC_W, SWAP, addr, ~data, got);
        check("amo_result_o", got, `LSU_SC_FAIL);
        load_check(LW, addr);
        // sc to a different word
        run_op(LR_W, SWAP, addr, 32'h0, got);
        run_op(SC_W, SWAP, addr ^ 32'h40, data, got);
        check("amo_result_o", got, `LSU_SC_FAIL);
        load_check(LW, addr ^ 32'h40);
        // plain store between lr and sc
        run_op(LR_W, SWAP, addr, 32'h0, got);
        data = rand_bits(32);
        run_op(SW, SWAP, addr, data, got);
        ref_store(SW, addr, data);
        run_op(SC_W, SWAP, addr, ~data, got);
        check("amo_result_o", got, `LSU_SC_FAIL);
        load_check(LW, addr);
        end_test("lr_sc");

        for (int lane = 1; lane < 4; lane++) begin
            op   = (lane == 1) ? AMO : (lane == 2) ? LR_W : SC_W;
            addr = 32'h1000_0000 | (rand_bits(6) << 2) | lane;
            run_op(op, ADD, addr, rand_bits(32), got);
            check("amo_misalign_o", misalign_seen, 1'b1);
            check("dcache_req_o.valid", req_seen.valid, 1'b0);
        end
        end_test("misalign");

        for (int n = 0; n < 4; n++) begin
            addr = rand_bits(32);
            run_op(NONE, SWAP, addr, rand_bits(32), got);
            check("mem_data_o", got, addr);
        end
        end_test("none");

        $display("%0d tests, %0d ops, %0d checks, %0d errors", tests, ops, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu_unit.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_op_decode.sv
rtl/lsu_lane_align.sv
rtl/lsu_amo_unit.sv
rtl/lsu_top.sv
tb/dcache_model.sv
tb/tb_lsu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the lsu testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -Irtl \
    -f lsu_unit.f --top-module tb_lsu_top -o sim_lsu &&
    ./obj_dir/sim_lsu > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^TESTBENCH PASSED$" sim.log && echo "run_sim: pass" && exit 0 ||
    { echo "run_sim: fail"; exit 1; }
